//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/cpu_chk.sv
module cpu_chk import cpu_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic            mem_we,
    input logic [XLEN-1:0] mem_addr,
    input logic [XLEN-1:0] im_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    we_low_in_reset: assert property (@(posedge clk) !arst_n |-> !mem_we)
        else $error("mem_we high while reset is asserted");

    store_word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> mem_addr[1:0] == 2'b00)
        else $error("store address not word aligned");

    // Fetch address always on a word boundary
    pc_word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        im_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

endmodule

bind cpu_top cpu_chk chk0 (.clk, .arst_n, .mem_we, .mem_addr, .im_addr);

//--- dv/stim_prog.txt
# I <byte address> <instruction word>   program memory
# D <byte address> <data word>          initial data memory, E <byte address> <data> expected stores
I 00000000 00500093
I 00000004 FFD00113
I 00000008 002081B3
I 0000000C 10302023
I 00000010 40208233
I 00000014 10402223
I 00000018 0020F2B3
I 0000001C 0020E333
I 00000020 0020C3B3
I 00000024 10502423
I 00000028 10602623
I 0000002C 10702823
I 00000030 00109433
I 00000034 001154B3
I 00000038 40115533
I 0000003C 001125B3
I 00000040 00113633
I 00000044 10802A23
I 00000048 10902C23
I 0000004C 10A02E23
I 00000050 12B02023
I 00000054 12C02223
I 00000058 0F017693
I 0000005C 1000E713
I 00000060 FFF0C793
I 00000064 00012813
I 00000068 0040B893
I 0000006C 00409913
I 00000070 01C15993
I 00000074 40115A13
I 00000078 12D02423
I 0000007C 12E02623
I 00000080 12F02823
I 00000084 13002A23
I 00000088 13102C23
I 0000008C 13202E23
I 00000090 15302023
I 00000094 15402223
I 00000098 20002A83
I 0000009C 001A8B33
I 000000A0 15602423
I 000000A4 00108663
I 000000A8 3E102823
I 000000AC 3E102A23
I 000000B0 00109663
I 000000B4 14102623
I 000000B8 00114463
I 000000BC 3E102C23
I 000000C0 00115463
I 000000C4 14202823
I 000000C8 0020D463
I 000000CC 3E102E23
I 000000D0 00C00BEF
I 000000D4 3E102823
I 000000D8 3E102A23
I 000000DC 15702A23
I 000000E0 00100073
D 00000200 11223344
E 00000100 00000002
E 00000104 00000008
E 00000108 00000005
E 0000010C FFFFFFFD
E 00000110 FFFFFFF8
E 00000114 000000A0
E 00000118 07FFFFFF
E 0000011C FFFFFFFF
E 00000120 00000001
E 00000124 00000000
E 00000128 000000F0
E 0000012C 00000105
E 00000130 FFFFFFFA
E 00000134 00000001
E 00000138 00000000
E 0000013C 00000050
E 00000140 0000000F
E 00000144 FFFFFFFE
E 00000148 11223349
E 0000014C 00000005
E 00000150 FFFFFFFD
E 00000154 000000D4

//--- dv/store_monitor.sv
module store_monitor import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            mem_we,
    input  logic [XLEN-1:0] mem_addr,
    input  logic [XLEN-1:0] mem_din,
    input  logic            ebreak,
    output int              errors,
    output int              pending
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [XLEN-1:0] exp_addr[$];
    logic [XLEN-1:0] exp_data[$];
    logic            ebreak_q;

    task automatic read_expected();
        int              fd;
        string           line;
        byte             kind;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        fd = $fopen("dv/stim_prog.txt", "r");
        if (fd == 0) begin
            $display("Store monitor could not open dv/stim_prog.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) continue;
            if ($sscanf(line, "%c %h %h", kind, a, d) != 3) continue;  // Comments, blanks
            if (kind == "E") begin
                exp_addr.push_back(a);
                exp_data.push_back(d);
            end
        end
        $fclose(fd);
        pending = exp_addr.size();
    endtask

    initial begin
        errors   = 0;
        pending  = 0;
        ebreak_q = 1'b0;
        read_expected();
    end

    always @(posedge clk) begin
        if (arst_n && mem_we) begin
            if (exp_addr.size() == 0) begin
                $display("[FAIL] %0t: unexpected store to %h data %h", $time, mem_addr, mem_din);
                errors++;
            end else begin
                if (mem_addr !== exp_addr[0] || mem_din !== exp_data[0]) begin
                    $display("[FAIL] %0t: store to %h data %h, expected %h data %h",
                             $time, mem_addr, mem_din, exp_addr[0], exp_data[0]);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                pending = exp_addr.size();
            end
        end
        if (arst_n && ebreak && exp_addr.size() != 0) begin
            $display("[FAIL] %0t: ebreak retired with %0d stores still expected",
                     $time, exp_addr.size());
            errors++;
        end
        if (arst_n && ebreak && ebreak_q) begin
            $display("[FAIL] %0t: ebreak high for more than one cycle", $time);
            errors++;
        end
        ebreak_q = arst_n && ebreak;  // One-cycle retirement pulse
    end

endmodule

//--- dv/tb_top.sv
module tb_top import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic            clk;
    logic            arst_n;
    logic [XLEN-1:0] im_addr;
    logic [XLEN-1:0] im_dout;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_din;
    logic [XLEN-1:0] mem_dout;
    logic            mem_we;
    logic            ebreak;
    logic [XLEN-1:0] imem [256];
    logic [XLEN-1:0] dmem [256];
    int              errors;
    int              pending;
    int              load_errors;
    int              cycles;
    int              timeout_cycles;
    logic            timed_out;

    cpu_top dut0 (
        .clk, .arst_n, .im_addr, .im_dout, .mem_addr, .mem_din, .mem_we, .mem_dout, .ebreak
    );

    store_monitor mon0 (
        .clk, .arst_n, .mem_we, .mem_addr, .mem_din, .ebreak, .errors, .pending
    );

    always #5 clk = ~clk;

    assign im_dout  = imem[im_addr[9:2]];   // Combinational fetch
    assign mem_dout = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[9:2]] <= mem_din;
        end
    end

    task automatic load_memories();
        int              fd;
        string           line;
        byte             kind;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (XLEN'(i) << 20) | 32'h0000_0013;  // addi x0, x0, i
            dmem[i] = 32'h5a5a_0000 ^ XLEN'(i * 4);
        end
        fd = $fopen("dv/stim_prog.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/stim_prog.txt");
            load_errors++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) continue;
            if ($sscanf(line, "%c %h %h", kind, a, d) != 3) continue;
            if (kind == "I") begin
                imem[a[9:2]] = d;
            end else if (kind == "D") begin
                dmem[a[9:2]] = d;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        cycles         = 0;
        load_errors    = 0;
        timeout_cycles = 2000;
        load_memories();
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        while (ebreak !== 1'b1 && cycles < timeout_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        timed_out = (ebreak !== 1'b1);
        if (timed_out) begin
            $display("Timeout: ebreak never arrived within %0d cycles", timeout_cycles);
        end else begin
            repeat (3) @(posedge clk);  // Let stray stores show up
            #1;
        end
        $display("Errors: %0d store mismatches, %0d stores missing, %0d load problems",
                 errors, pending, load_errors);
        if (!timed_out && errors == 0 && pending == 0 && load_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC    = '0;
    localparam logic [XLEN-1:0] NOP_INST    = 32'h0000_0033;  // add x0, x0, x0
    localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM} wb_sel_t;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_JUMP} br_op_t;

    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_t;

    // All-zero word is the bubble
    typedef struct packed {
        logic    rf_we;
        wb_sel_t wb_sel;
        alu_op_t alu_op;
        logic    src1_pc;   // ALU A from pc
        logic    src2_imm;  // ALU B from imm
        br_op_t  br_op;
        logic    mem_we;
        logic    is_load;
        logic    is_ebreak;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_plus4;
        logic [XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   pc_plus4;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rd1;
        logic [XLEN-1:0]   rd2;
        logic [XLEN-1:0]   imm;
        ctrl_t             ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc_plus4;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   alu_res;
        logic [XLEN-1:0]   store_data;
        ctrl_t             ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wb_data;
        ctrl_t             ctrl;
    } mem_wb_t;

endpackage

//--- rtl/cpu_top.sv
module cpu_top import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    output logic [XLEN-1:0] im_addr,
    input  logic [XLEN-1:0] im_dout,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_din,
    output logic            mem_we,
    input  logic [XLEN-1:0] mem_dout,
    output logic            ebreak
);

    if_id_t            if_d;
    if_id_t            if_q;
    id_ex_t            ex_d;
    id_ex_t            ex_q;
    ex_mem_t           mem_d;
    ex_mem_t           mem_q;
    mem_wb_t           wb_d;
    mem_wb_t           wb_q;
    logic [REG_AW-1:0] dec_rs1;
    logic [REG_AW-1:0] dec_rs2;
    logic [REG_AW-1:0] dec_rd;
    logic [XLEN-1:0]   dec_imm;
    ctrl_t             dec_ctrl;
    logic [XLEN-1:0]   rf_rd0;
    logic [XLEN-1:0]   rf_rd1;
    fwd_sel_t          fwd0;
    fwd_sel_t          fwd1;
    logic              stall_front;
    logic              bubble_mem;
    logic              flush_id;
    logic              flush_ex;
    logic              redirect;
    logic [XLEN-1:0]   target;

    fetch_unit fetch0 (
        .clk, .arst_n, .stall(stall_front), .redirect(flush_id), .target,
        .im_dout, .pc(im_addr), .if_out(if_d)
    );

    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk, .arst_n, .stall(stall_front), .flush(1'b0), .d(if_d), .q(if_q)
    );

    decoder dec0 (
        .inst(if_q.inst), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm),
        .ctrl(dec_ctrl)
    );

    reg_file rf0 (
        .clk, .arst_n, .we(wb_q.ctrl.rf_we), .ra0(dec_rs1), .ra1(dec_rs2), .wa(wb_q.rd),
        .wd(wb_q.wb_data), .rd0(rf_rd0), .rd1(rf_rd1)
    );

    always_comb begin
        if (stall_front) begin
            // Load-use hold; the WB producer is gone by the replay cycle
            ex_d = ex_q;
            if (fwd0 == FWD_WB) begin
                ex_d.rd1 = wb_q.wb_data;
            end
            if (fwd1 == FWD_WB) begin
                ex_d.rd2 = wb_q.wb_data;
            end
        end else begin
            ex_d.pc       = if_q.pc;
            ex_d.pc_plus4 = if_q.pc_plus4;
            ex_d.rs1      = dec_rs1;
            ex_d.rs2      = dec_rs2;
            ex_d.rd       = dec_rd;
            ex_d.rd1      = rf_rd0;
            ex_d.rd2      = rf_rd1;
            ex_d.imm      = dec_imm;
            ex_d.ctrl     = dec_ctrl;
        end
    end

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk, .arst_n, .stall(1'b0), .flush(flush_ex), .d(ex_d), .q(ex_q)
    );

    execute_unit exe0 (
        .ex_in(ex_q), .fwd0, .fwd1, .mem_fwd(wb_d.wb_data), .wb_fwd(wb_q.wb_data),
        .ex_out(mem_d), .redirect, .target
    );

    hazard_unit hzd0 (
        .rs1_ex(ex_q.rs1), .rs2_ex(ex_q.rs2), .rd_mem(mem_q.rd), .rd_wb(wb_q.rd),
        .rf_we_mem(mem_q.ctrl.rf_we), .is_load_mem(mem_q.ctrl.is_load),
        .rf_we_wb(wb_q.ctrl.rf_we), .redirect, .fwd0, .fwd1, .stall_front, .bubble_mem,
        .flush_id, .flush_ex
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk, .arst_n, .stall(1'b0), .flush(bubble_mem), .d(mem_d), .q(mem_q)
    );

    assign mem_addr = mem_q.alu_res;
    assign mem_din  = mem_q.store_data;
    assign mem_we   = mem_q.ctrl.mem_we;

    always_comb begin
        wb_d.rd   = mem_q.rd;
        wb_d.ctrl = mem_q.ctrl;
        case (mem_q.ctrl.wb_sel)
            WB_PC4:  wb_d.wb_data = mem_q.pc_plus4;  // jal link
            WB_MEM:  wb_d.wb_data = mem_dout;
            default: wb_d.wb_data = mem_q.alu_res;
        endcase
    end

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk, .arst_n, .stall(1'b0), .flush(1'b0), .d(wb_d), .q(wb_q)
    );

    assign ebreak = wb_q.ctrl.is_ebreak;

endmodule

//--- rtl/decoder.sv
module decoder import cpu_pkg::*; (
    input  logic [XLEN-1:0]   inst,
    output logic [REG_AW-1:0] rs1,
    output logic [REG_AW-1:0] rs2,
    output logic [REG_AW-1:0] rd,
    output logic [XLEN-1:0]   imm,
    output ctrl_t             ctrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            legal;
    logic            use_rs1;
    logic            use_rs2;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        legal   = 1'b1;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                use_rs1      = 1'b1;
                use_rs2      = (opcode == OPC_OP);
                ctrl.rf_we   = 1'b1;
                ctrl.src2_imm = (opcode == OPC_OP_IMM);
                imm          = imm_i;
                case (funct3)
                    3'b000: ctrl.alu_op = (use_rs2 && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001: ctrl.alu_op = ALU_SLL;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b101: ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
                // funct7 only matters for shifts, and for sub in OP
                if ((use_rs2 || funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'h00) begin
                    legal = (funct7 == 7'h20) && (funct3 == 3'b101 || (use_rs2 && funct3 == 3'b000));
                end
            end
            OPC_LOAD: begin
                legal         = (funct3 == 3'b010);  // lw only
                use_rs1       = 1'b1;
                ctrl.rf_we    = 1'b1;
                ctrl.wb_sel   = WB_MEM;
                ctrl.is_load  = 1'b1;
                ctrl.src2_imm = 1'b1;
                imm           = imm_i;
            end
            OPC_STORE: begin
                legal         = (funct3 == 3'b010);
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                ctrl.mem_we   = 1'b1;
                ctrl.src2_imm = 1'b1;
                imm           = imm_s;
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm     = imm_b;
                case (funct3)
                    3'b000: ctrl.br_op = BR_EQ;
                    3'b001: ctrl.br_op = BR_NE;
                    3'b100: ctrl.br_op = BR_LT;
                    3'b101: ctrl.br_op = BR_GE;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wb_sel   = WB_PC4;
                ctrl.br_op    = BR_JUMP;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
                imm           = imm_j;
            end
            OPC_SYSTEM: begin
                legal          = (inst == EBREAK_INST);
                ctrl.is_ebreak = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl    = '0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    // Unused sources read as x0 so they never forward or stall
    assign rs1 = use_rs1 ? inst[19:15] : '0;
    assign rs2 = use_rs2 ? inst[24:20] : '0;
    assign rd  = ctrl.rf_we ? inst[11:7] : '0;

endmodule

//--- rtl/execute_unit.sv
module execute_unit import cpu_pkg::*; (
    input  id_ex_t          ex_in,
    input  fwd_sel_t        fwd0,
    input  fwd_sel_t        fwd1,
    input  logic [XLEN-1:0] mem_fwd,
    input  logic [XLEN-1:0] wb_fwd,
    output ex_mem_t         ex_out,
    output logic            redirect,
    output logic [XLEN-1:0] target
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_res;

    function automatic logic [XLEN-1:0] pick(input fwd_sel_t sel, input logic [XLEN-1:0] rf_val,
                                             input logic [XLEN-1:0] m_val,
                                             input logic [XLEN-1:0] w_val);
        case (sel)
            FWD_MEM: return m_val;
            FWD_WB:  return w_val;
            default: return rf_val;
        endcase
    endfunction

    assign op1  = pick(fwd0, ex_in.rd1, mem_fwd, wb_fwd);
    assign op2  = pick(fwd1, ex_in.rd2, mem_fwd, wb_fwd);
    assign src1 = ex_in.ctrl.src1_pc ? ex_in.pc : op1;
    assign src2 = ex_in.ctrl.src2_imm ? ex_in.imm : op2;

    always_comb begin
        case (ex_in.ctrl.alu_op)
            ALU_ADD:  alu_res = src1 + src2;
            ALU_SUB:  alu_res = src1 - src2;
            ALU_AND:  alu_res = src1 & src2;
            ALU_OR:   alu_res = src1 | src2;
            ALU_XOR:  alu_res = src1 ^ src2;
            ALU_SLL:  alu_res = src1 << src2[4:0];
            ALU_SRL:  alu_res = src1 >> src2[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(src1) >>> src2[4:0]);
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, src1 < src2};
            default:  alu_res = '0;
        endcase
    end

    // Compare on forwarded registers, never on the ALU inputs
    always_comb begin
        case (ex_in.ctrl.br_op)
            BR_EQ:   redirect = (op1 == op2);
            BR_NE:   redirect = (op1 != op2);
            BR_LT:   redirect = $signed(op1) < $signed(op2);
            BR_GE:   redirect = $signed(op1) >= $signed(op2);
            BR_JUMP: redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    assign target = ex_in.pc + ex_in.imm;

    always_comb begin
        ex_out.pc_plus4   = ex_in.pc_plus4;
        ex_out.rd         = ex_in.rd;
        ex_out.alu_res    = alu_res;   // Also the lw/sw address
        ex_out.store_data = op2;
        ex_out.ctrl       = ex_in.ctrl;
    end

endmodule

//--- rtl/fetch_unit.sv
module fetch_unit import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall,
    input  logic            redirect,
    input  logic [XLEN-1:0] target,
    input  logic [XLEN-1:0] im_dout,
    output logic [XLEN-1:0] pc,
    output if_id_t          if_out
);

    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4 = pc + XLEN'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    always_comb begin
        if_out.pc       = pc;
        if_out.pc_plus4 = pc_plus4;
        if_out.inst     = redirect ? NOP_INST : im_dout;  // Wrong-path slot
    end

endmodule

//--- rtl/hazard_unit.sv
module hazard_unit import cpu_pkg::*; (
    input  logic [REG_AW-1:0] rs1_ex,
    input  logic [REG_AW-1:0] rs2_ex,
    input  logic [REG_AW-1:0] rd_mem,
    input  logic [REG_AW-1:0] rd_wb,
    input  logic              rf_we_mem,
    input  logic              is_load_mem,
    input  logic              rf_we_wb,
    input  logic              redirect,
    output fwd_sel_t          fwd0,
    output fwd_sel_t          fwd1,
    output logic              stall_front,
    output logic              bubble_mem,
    output logic              flush_id,
    output logic              flush_ex
);

    // Youngest producer first
    function automatic fwd_sel_t fwd_src(input logic [REG_AW-1:0] rs);
        if (rs == '0) begin
            return FWD_RF;
        end
        if (rf_we_mem && rd_mem == rs) begin
            return FWD_MEM;
        end
        if (rf_we_wb && rd_wb == rs) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        fwd0        = fwd_src(rs1_ex);
        fwd1        = fwd_src(rs2_ex);
        stall_front = is_load_mem && rd_mem != '0 && (rd_mem == rs1_ex || rd_mem == rs2_ex);
        bubble_mem  = stall_front;
        // A stalled branch compares stale operands, so hold off the redirect
        flush_id    = redirect && !stall_front;
        flush_ex    = redirect && !stall_front;
    end

endmodule

//--- rtl/reg_file.sv
module reg_file import cpu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              we,
    input  logic [REG_AW-1:0] ra0,
    input  logic [REG_AW-1:0] ra1,
    input  logic [REG_AW-1:0] wa,
    input  logic [XLEN-1:0]   wd,
    output logic [XLEN-1:0]   rd0,
    output logic [XLEN-1:0]   rd1
);

    logic [XLEN-1:0] regs [1:2**REG_AW-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] ra);
        if (ra == '0) begin
            return '0;
        end
        if (we && wa == ra) begin
            return wd;  // Write-through
        end
        return regs[ra];
    endfunction

    always_comb begin
        rd0 = read_port(ra0);
        rd1 = read_port(ra1);
    end

endmodule

//--- rtl/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;  // Bubble, wins over stall
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

//--- sim.f
rtl/cpu_pkg.sv
rtl/stage_reg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/hazard_unit.sv
rtl/cpu_top.sv
dv/cpu_chk.sv
dv/store_monitor.sv
dv/tb_top.sv
